// File: filelist.f
+incdir+include
rtl/decode_pkg.sv
rtl/inst_decoder.sv
rtl/dispatch_slots.sv
rtl/decode_dispatch.sv
verification/tb_decode_dispatch.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := tb_decode_dispatch
FILELIST  := filelist.f
OBJ_DIR   := obj_dir
PASS_MSG  := PASS: all tests

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: include/decode_expect.svh
// include inside a module that imports decode_pkg; models the decode, count and slot update rules
`ifndef DECODE_EXPECT_SVH
`define DECODE_EXPECT_SVH

  // expected decode of one fetch lane
  function automatic decoded_slot_t expect_decode(input fetch_lane_t ln);
    decoded_slot_t e;
    logic [5:0]    op;
    logic [6:0]    fn;
    op = ln.inst.op.opcode;
    fn = ln.inst.op.func;
    e = noop_slot;
    e.npc = ln.npc;
    e.inst = ln.inst;
    e.ra_idx = ln.inst.op.ra;
    e.rb_idx = ln.inst.op.rb;
    e.rc_idx = ln.inst.op.rc;
    if (ln.valid && op inside {[6'h00:6'h07]})
      e.illegal = !(op == pal_inst && ln.inst[25:0] == pal_halt);
    if (ln.valid && op inside {[6'h00:6'h07]})
      e.halt = !e.illegal;
    if (ln.valid && op inside {[6'h10:6'h17]})
    begin
      e.opb_sel = ln.inst.op.lit ? opb_is_alu_imm : opb_is_regb;
      e.dest_idx = ln.inst.op.rc;
      if (op == inta_grp && fn == subq_fn) e.alu_func = alu_subq;
      else if (op == inta_grp && fn == cmpeq_fn) e.alu_func = alu_cmpeq;
      else if (op == inta_grp && fn == cmplt_fn) e.alu_func = alu_cmplt;
      else if (op == inta_grp && fn == cmple_fn) e.alu_func = alu_cmple;
      else if (op == inta_grp && fn == cmpult_fn) e.alu_func = alu_cmpult;
      else if (op == inta_grp && fn == cmpule_fn) e.alu_func = alu_cmpule;
      else if (op == intl_grp && fn == and_fn) e.alu_func = alu_and;
      else if (op == intl_grp && fn == bic_fn) e.alu_func = alu_bic;
      else if (op == intl_grp && fn == bis_fn) e.alu_func = alu_bis;
      else if (op == intl_grp && fn == ornot_fn) e.alu_func = alu_ornot;
      else if (op == intl_grp && fn == xor_fn) e.alu_func = alu_xor;
      else if (op == intl_grp && fn == eqv_fn) e.alu_func = alu_eqv;
      else if (op == ints_grp && fn == srl_fn) e.alu_func = alu_srl;
      else if (op == ints_grp && fn == sll_fn) e.alu_func = alu_sll;
      else if (op == ints_grp && fn == sra_fn) e.alu_func = alu_sra;
      else if (op == intm_grp && fn == mulq_fn) e.alu_func = alu_mulq;
      else e.illegal = !(op == inta_grp && fn == addq_fn);
    end
    if (ln.valid && op inside {[6'h18:6'h1f]})
    begin
      e.illegal = (op != jsr_grp);
      e.opa_sel = e.illegal ? opa_is_rega : opa_is_not3;
      e.alu_func = e.illegal ? alu_addq : alu_and;
      e.dest_idx = e.illegal ? zero_reg : ln.inst.op.ra;
      e.uncond_branch = !e.illegal;
    end
    if (ln.valid && op inside {[6'h08:6'h0f], [6'h20:6'h2f]})
    begin
      e.opa_sel = opa_is_mem_disp;
      e.dest_idx = (op == stq_inst) ? zero_reg : ln.inst.mem.ra;
      e.rd_mem = (op == ldq_inst);
      e.wr_mem = (op == stq_inst);
      e.illegal = !(op inside {lda_inst, ldq_inst, stq_inst});
    end
    if (ln.valid && op inside {[6'h30:6'h3f]})
    begin
      e.opa_sel = opa_is_npc;
      e.opb_sel = opb_is_br_disp;
      e.illegal = op inside {fbeq_inst, fblt_inst, fble_inst, fbne_inst, fbge_inst, fbgt_inst};
      e.uncond_branch = op inside {br_inst, bsr_inst};
      e.dest_idx = e.uncond_branch ? ln.inst.mem.ra : zero_reg;
      e.cond_branch = !e.illegal && !e.uncond_branch;
    end
    e.valid = ln.valid & ~e.illegal;
    return e;
  endfunction

  function automatic logic [1:0] expect_dispatch_num(input logic [1:0] rob, input logic [1:0] rs);
    if (rob == 2'd2 && rs == 2'd2)
      return 2'd2;
    return (rob == 2'd0 || rs == 2'd0) ? 2'd0 : 2'd1;
  endfunction

  // stored slot idx after an edge taken with count num
  function automatic decoded_slot_t expect_next_slot(input int idx, input logic [1:0] num,
      input decoded_slot_t old0, input decoded_slot_t old1,
      input decoded_slot_t dec0, input decoded_slot_t dec1);
    if (num == 2'd2)
      return (idx == 0) ? dec0 : dec1;
    if (num == 2'd1)
      return (idx == 0) ? old1 : dec0;
    return (idx == 0) ? old0 : old1;
  endfunction

  function automatic logic expect_valid_out(input int idx, input logic stored,
      input logic [1:0] num);
    return stored & ((idx == 0) ? (num != 2'd0) : (num == 2'd2));
  endfunction

`endif

// File: verification/tb_decode_dispatch.sv
// directed checks through the top level; lanes driven on falling edges, one cycle per step
`timescale 1ns/1ps
`default_nettype none

module tb_decode_dispatch
  import decode_pkg::*;
();

  `include "decode_expect.svh"

  localparam int test_cycles = 5 + 21 + 5 + 7 + 16 + 7 + 1; // reset, tests, final look
  localparam int max_cycles  = 2 * test_cycles + 20;

  // operate pairs {opcode, function}, the last four are unknown encodings
  localparam logic [12:0] op_tab [21] = '{
    {inta_grp, addq_fn}, {inta_grp, subq_fn}, {inta_grp, cmpeq_fn}, {inta_grp, cmplt_fn},
    {inta_grp, cmple_fn}, {inta_grp, cmpult_fn}, {inta_grp, cmpule_fn}, {intl_grp, and_fn},
    {intl_grp, bic_fn}, {intl_grp, bis_fn}, {intl_grp, ornot_fn}, {intl_grp, xor_fn},
    {intl_grp, eqv_fn}, {ints_grp, srl_fn}, {ints_grp, sll_fn}, {ints_grp, sra_fn},
    {intm_grp, mulq_fn},
    {inta_grp, 7'h7f}, {intl_grp, 7'h7f}, {ints_grp, 7'h00}, {intm_grp, 7'h30}
  };
  localparam logic [5:0] mb_tab [10] = '{
    ldq_inst, lda_inst, stq_inst, jsr_grp, br_inst,
    bsr_inst, 6'h39, 6'h3d, 6'h38, 6'h3e          // beq, bne, blbc, bge
  };

  logic          clock = 1'b0;
  logic          reset;
  fetch_lane_t   lanes [num_lanes];
  logic [1:0]    rob_cap;
  logic [1:0]    rs_cap;
  decoded_slot_t slots [num_lanes];
  logic [1:0]    dispatch_num;

  decoded_slot_t model_q [num_lanes];  // expected stored slot pair
  integer        seed;
  int            errors = 0;
  int            cycles = 0;

  decode_dispatch dut (
    .clock        (clock),
    .reset        (reset),
    .lanes        (lanes),
    .rob_cap      (rob_cap),
    .rs_cap       (rs_cap),
    .slots        (slots),
    .dispatch_num (dispatch_num)
  );

  always #5 clock = ~clock;            // 10 ns period

  always @(posedge clock)
  begin
    cycles = cycles + 1;
    if (cycles >= max_cycles)
    begin
      $display("timeout: run did not finish within %0d cycles", max_cycles);
      $display("FAIL: see errors above");
      $finish;
    end
  end

  function automatic fetch_lane_t make_op(input logic [5:0] opc, input logic [6:0] fn,
      input logic lit);
    fetch_lane_t ln;
    logic [31:0] r;
    r = $random(seed);
    ln.valid = 1'b1;
    ln.npc = {$random(seed), $random(seed)};
    ln.inst.op.opcode = opc;
    ln.inst.op.ra = r[4:0];
    ln.inst.op.rb = r[9:5];
    ln.inst.op.lit_or_zero = lit ? r[12:10] : 3'b000; // sbz in register form
    ln.inst.op.lit = lit;
    ln.inst.op.func = fn;
    ln.inst.op.rc = r[17:13];
    return ln;
  endfunction

  function automatic fetch_lane_t make_mem(input logic [5:0] opc);
    fetch_lane_t ln;
    logic [31:0] r;
    r = $random(seed);
    ln.valid = 1'b1;
    ln.npc = {$random(seed), $random(seed)};
    ln.inst.mem.opcode = opc;
    ln.inst.mem.ra = r[4:0];
    ln.inst.mem.rb = r[9:5];
    ln.inst.mem.disp = r[31:16];
    return ln;
  endfunction

  function automatic fetch_lane_t make_word(input logic vld, input logic [31:0] word);
    fetch_lane_t ln;
    ln.valid = vld;
    ln.npc = {$random(seed), $random(seed)};
    ln.inst = word;
    return ln;
  endfunction

  // compare count and both slot outputs against the model
  task automatic check_outputs(input logic [1:0] num);
    decoded_slot_t exp;
    assert (dispatch_num === num)
    else
    begin
      $display("Error: dispatch_num got %h expected %h", dispatch_num, num);
      errors++;
    end
    for (int i = 0; i < num_lanes; i++)
    begin
      exp = model_q[i];
      exp.valid = expect_valid_out(i, model_q[i].valid, num); // qualified by count
      assert (slots[i] === exp)
      else
      begin
        $display("Error: slots[%0d] got %h expected %h", i, slots[i], exp);
        errors++;
      end
    end
  endtask

  // one cycle from a falling edge: drive, check what is visible now, let the edge take the lanes
  task automatic drive_cycle(input fetch_lane_t l0, input fetch_lane_t l1,
      input logic [1:0] rob, input logic [1:0] rs);
    decoded_slot_t d0;
    decoded_slot_t d1;
    decoded_slot_t n0;
    decoded_slot_t n1;
    logic [1:0]    num;
    lanes[0] = l0;
    lanes[1] = l1;
    rob_cap = rob;
    rs_cap = rs;
    #2;                                  // settle mid low phase
    num = expect_dispatch_num(rob, rs);
    check_outputs(num);
    d0 = expect_decode(l0);
    d1 = expect_decode(l1);
    n0 = expect_next_slot(0, num, model_q[0], model_q[1], d0, d1);
    n1 = expect_next_slot(1, num, model_q[0], model_q[1], d0, d1);
    @(posedge clock);
    model_q[0] = n0;
    model_q[1] = n1;
    @(negedge clock);                    // next step starts here
  endtask

  task automatic reset_test();
    for (int i = 0; i < 5; i++)
    begin
      @(negedge clock);
      check_outputs(2'd2);               // noop slots, valid gated off
    end
    reset = 1'b0;                        // released after 5 rising edges
  endtask

  task automatic operate_test();
    for (int i = 0; i < 21; i++)
      drive_cycle(make_op(op_tab[i][12:7], op_tab[i][6:0], 1'b0),
                  make_op(op_tab[i][12:7], op_tab[i][6:0], 1'b1), 2'd2, 2'd2);
  endtask

  task automatic mem_branch_test();
    for (int i = 0; i < 10; i += 2)
      drive_cycle(make_mem(mb_tab[i]), make_mem(mb_tab[i+1]), 2'd2, 2'd2);
  endtask

  task automatic halt_illegal_test();
    drive_cycle(make_word(1'b1, {pal_inst, pal_halt}), make_word(1'b1, {pal_inst, 26'h9f}),
                2'd2, 2'd2);             // halt, cpuid
    drive_cycle(make_word(1'b1, {pal_inst, 26'h83}), make_mem(6'h2b), 2'd2, 2'd2); // ldq_l
    drive_cycle(make_mem(6'h2f), make_mem(fbeq_inst), 2'd2, 2'd2);                 // stq_c
    drive_cycle(make_mem(fblt_inst), make_mem(fble_inst), 2'd2, 2'd2);
    drive_cycle(make_mem(fbne_inst), make_mem(fbge_inst), 2'd2, 2'd2);
    drive_cycle(make_mem(fbgt_inst), make_mem(6'h1c), 2'd2, 2'd2);
    drive_cycle(make_word(1'b0, $random(seed)), make_word(1'b0, {pal_inst, pal_halt}),
                2'd2, 2'd2);             // invalid lanes
  endtask

  task automatic count_shift_test();
    for (int rob = 0; rob < 4; rob++)
      for (int rs = 0; rs < 4; rs++)
        drive_cycle(make_op(intl_grp, xor_fn, rs[0]), make_mem(ldq_inst), rob[1:0], rs[1:0]);
  endtask

  task automatic stall_test();
    drive_cycle(make_op(inta_grp, subq_fn, 1'b0), make_mem(stq_inst), 2'd2, 2'd2);
    drive_cycle(make_mem(ldq_inst), make_mem(lda_inst), 2'd0, 2'd2);
    drive_cycle(make_mem(br_inst), make_mem(bsr_inst), 2'd2, 2'd0);
    drive_cycle(make_op(intm_grp, mulq_fn, 1'b1), make_mem(jsr_grp), 2'd0, 2'd0);
    drive_cycle(make_op(ints_grp, sll_fn, 1'b0), make_mem(6'h39), 2'd0, 2'd3);
    drive_cycle(make_op(intl_grp, bis_fn, 1'b1), make_mem(ldq_inst), 2'd3, 2'd0);
    drive_cycle(make_mem(lda_inst), make_mem(stq_inst), 2'd1, 2'd1); // shift out held pair
  endtask

  initial
  begin
    seed = 32'hd690;
    reset = 1'b1;
    rob_cap = 2'd2;
    rs_cap = 2'd2;
    lanes[0] = make_word(1'b0, noop_inst);
    lanes[1] = make_word(1'b0, noop_inst);
    model_q[0] = noop_slot;
    model_q[1] = noop_slot;
    reset_test();
    operate_test();
    mem_branch_test();
    halt_illegal_test();
    count_shift_test();
    stall_test();
    drive_cycle(make_word(1'b0, noop_inst), make_word(1'b0, noop_inst), 2'd2, 2'd2);
    $display("errors: %0d", errors);
    if (errors == 0)
      $display("PASS: all tests");
    else
      $display("FAIL: see errors above");
    $finish;
  end

endmodule

`default_nettype wire

// File: rtl/decode_dispatch.sv
// decode is zero-cycle; a lane taken at an edge shows in the slot outputs after that edge
`timescale 1ns/1ps
`default_nettype none

module decode_dispatch
  import decode_pkg::*;
(
  input  logic          clock,
  input  logic          reset,
  input  fetch_lane_t   lanes [num_lanes],  // straight from fetch
  input  logic [1:0]    rob_cap,
  input  logic [1:0]    rs_cap,
  output decoded_slot_t slots [num_lanes],  // toward rs, rob and map table
  output logic [1:0]    dispatch_num
);

  decoded_slot_t decoded [num_lanes];       // per-lane decode results

  // identical decoder per fetch lane
  for (genvar g = 0; g < num_lanes; g++)
  begin : g_lane
    inst_decoder u_dec (
      .lane (lanes[g]),
      .slot (decoded[g])
    );
  end

  dispatch_slots u_slots (
    .clock        (clock),
    .reset        (reset),
    .decoded      (decoded),
    .rob_cap      (rob_cap),
    .rs_cap       (rs_cap),
    .slots        (slots),
    .dispatch_num (dispatch_num)
  );

endmodule

`default_nettype wire

// File: rtl/dispatch_slots.sv
// capacities above 2 are treated as 1; slot contents hold whenever either capacity is 0
`timescale 1ns/1ps
`default_nettype none

module dispatch_slots
  import decode_pkg::*;
(
  input  logic          clock,
  input  logic          reset,
  input  decoded_slot_t decoded [num_lanes],
  input  logic [1:0]    rob_cap,          // free rob entries
  input  logic [1:0]    rs_cap,           // free rs entries
  output decoded_slot_t slots [num_lanes],
  output logic [1:0]    dispatch_num      // lanes consumed this cycle
);

  decoded_slot_t slot_q [num_lanes];      // stored slot pair

  // both structures must take the pair before two go out
  always_comb
  begin
    if (rob_cap == 2'd2 && rs_cap == 2'd2)
      dispatch_num = 2'd2;
    else if (rob_cap == 2'd0 || rs_cap == 2'd0)
      dispatch_num = 2'd0;                // stall, fetch holds its lanes
    else
      dispatch_num = 2'd1;
  end

  // stored fields go out as is, only valid is gated by this cycle's count
  always_comb
  begin
    slots          = slot_q;
    slots[0].valid = slot_q[0].valid & (dispatch_num != 2'd0);
    slots[1].valid = slot_q[1].valid & (dispatch_num == 2'd2);
  end

  always_ff @(posedge clock)
  begin
    if (reset)
    begin
      slot_q[0] <= noop_slot;
      slot_q[1] <= noop_slot;
    end
    else
    begin
      case (dispatch_num)
        2'd2:                             // whole pair taken, reload
        begin
          slot_q[0] <= decoded[0];
          slot_q[1] <= decoded[1];
        end
        2'd1:                             // older slot 1 moves up
        begin
          slot_q[0] <= slot_q[1];
          slot_q[1] <= decoded[0];
        end
        default:                          // hold
        begin
          slot_q[0] <= slot_q[0];
          slot_q[1] <= slot_q[1];
        end
      endcase
    end
  end

endmodule

`default_nettype wire

// File: rtl/inst_decoder.sv
// purely combinational; illegal words keep their group's partial selects but valid drops
`timescale 1ns/1ps
`default_nettype none

module inst_decoder
  import decode_pkg::*;
(
  input  fetch_lane_t   lane,
  output decoded_slot_t slot
);

  always_comb
  begin
    slot          = noop_slot;          // noop defaults, all flags clear
    slot.npc      = lane.npc;
    slot.inst     = lane.inst;
    slot.ra_idx   = lane.inst.op.ra;    // register fields pass through
    slot.rb_idx   = lane.inst.op.rb;
    slot.rc_idx   = lane.inst.op.rc;
    if (lane.valid)
    begin
      case (lane.inst.op.opcode[5:3])
        3'b000:                           // pal group
        begin
          if (lane.inst.op.opcode == pal_inst && lane.inst[25:0] == pal_halt)
            slot.halt = 1'b1;
          else
            slot.illegal = 1'b1;            // cpuid and other pal calls
        end
        3'b010:                           // integer operates
        begin
          slot.opa_sel  = opa_is_rega;
          slot.opb_sel  = lane.inst.op.lit ? opb_is_alu_imm : opb_is_regb;
          slot.dest_idx = lane.inst.op.rc;
          case (lane.inst.op.opcode)
            inta_grp:
              case (lane.inst.op.func)
                addq_fn:   slot.alu_func = alu_addq;
                subq_fn:   slot.alu_func = alu_subq;
                cmpeq_fn:  slot.alu_func = alu_cmpeq;
                cmplt_fn:  slot.alu_func = alu_cmplt;
                cmple_fn:  slot.alu_func = alu_cmple;
                cmpult_fn: slot.alu_func = alu_cmpult;
                cmpule_fn: slot.alu_func = alu_cmpule;
                default:   slot.illegal  = 1'b1;
              endcase
            intl_grp:
              case (lane.inst.op.func)
                and_fn:   slot.alu_func = alu_and;
                bic_fn:   slot.alu_func = alu_bic;
                bis_fn:   slot.alu_func = alu_bis;
                ornot_fn: slot.alu_func = alu_ornot;
                xor_fn:   slot.alu_func = alu_xor;
                eqv_fn:   slot.alu_func = alu_eqv;
                default:  slot.illegal  = 1'b1;
              endcase
            ints_grp:
              case (lane.inst.op.func)
                srl_fn:  slot.alu_func = alu_srl;
                sll_fn:  slot.alu_func = alu_sll;
                sra_fn:  slot.alu_func = alu_sra;
                default: slot.illegal  = 1'b1;
              endcase
            intm_grp:
              if (lane.inst.op.func == mulq_fn)
                slot.alu_func = alu_mulq;
              else
                slot.illegal = 1'b1;
            default: slot.illegal = 1'b1;   // fp operate groups
          endcase
        end
        3'b011:                           // misc, jump, fp convert
        begin
          if (lane.inst.op.opcode == jsr_grp)
          begin
            slot.opa_sel       = opa_is_not3;
            slot.opb_sel       = opb_is_regb;
            slot.alu_func      = alu_and;   // target = rb & ~3
            slot.dest_idx      = lane.inst.op.ra; // return address
            slot.uncond_branch = 1'b1;
          end
          else
            slot.illegal = 1'b1;
        end
        3'b001, 3'b100, 3'b101:           // memory format
        begin
          slot.opa_sel  = opa_is_mem_disp;
          slot.opb_sel  = opb_is_regb;
          slot.alu_func = alu_addq;         // address = rb + disp
          slot.dest_idx = lane.inst.mem.ra;
          case (lane.inst.mem.opcode)
            lda_inst: ;                     // address itself is the result
            ldq_inst: slot.rd_mem = 1'b1;
            stq_inst:
            begin
              slot.wr_mem   = 1'b1;
              slot.dest_idx = zero_reg;     // store has no writeback
            end
            default: slot.illegal = 1'b1;   // ldah, ldq_l, stq_c and the rest
          endcase
        end
        default:                          // 3'b110, 3'b111 branch format
        begin
          slot.opa_sel  = opa_is_npc;
          slot.opb_sel  = opb_is_br_disp;
          slot.alu_func = alu_addq;         // target = npc + disp*4
          case (lane.inst.mem.opcode)
            fbeq_inst, fblt_inst, fble_inst,
            fbne_inst, fbge_inst, fbgt_inst:
              slot.illegal = 1'b1;          // no fp condition source
            br_inst, bsr_inst:
            begin
              slot.dest_idx      = lane.inst.mem.ra; // link register
              slot.uncond_branch = 1'b1;
            end
            default: slot.cond_branch = 1'b1;
          endcase
        end
      endcase
    end
    slot.valid = lane.valid & ~slot.illegal; // halt stays valid
  end

endmodule

`default_nettype wire

// File: rtl/decode_pkg.sv
// two lanes only, integer subset; ldq_l, stq_c, cpuid and fp/misc groups decode as illegal
`default_nettype none

package decode_pkg;

  localparam int num_lanes = 2;          // fetch and dispatch width
  localparam int reg_idx_w = 5;
  localparam logic [reg_idx_w-1:0] zero_reg = 5'd31;  // no writeback
  localparam logic [31:0] noop_inst = 32'h47ff041f;   // bis r31,r31,r31

  // major opcodes
  localparam logic [5:0] pal_inst = 6'h00;
  localparam logic [5:0] lda_inst = 6'h08;
  localparam logic [5:0] inta_grp = 6'h10; // add/sub/compare
  localparam logic [5:0] intl_grp = 6'h11; // logical
  localparam logic [5:0] ints_grp = 6'h12; // shifts
  localparam logic [5:0] intm_grp = 6'h13; // multiply
  localparam logic [5:0] jsr_grp  = 6'h1a; // jmp/jsr/ret/jsr_co
  localparam logic [5:0] ldq_inst = 6'h29;
  localparam logic [5:0] stq_inst = 6'h2d;
  localparam logic [5:0] br_inst  = 6'h30;
  localparam logic [5:0] fbeq_inst = 6'h31; // fp branches, never implemented
  localparam logic [5:0] fblt_inst = 6'h32;
  localparam logic [5:0] fble_inst = 6'h33;
  localparam logic [5:0] bsr_inst  = 6'h34;
  localparam logic [5:0] fbne_inst = 6'h35;
  localparam logic [5:0] fbge_inst = 6'h36;
  localparam logic [5:0] fbgt_inst = 6'h37;

  localparam logic [25:0] pal_halt = 26'h555; // pal function of halt

  // operate function codes, bits 11:5
  localparam logic [6:0] addq_fn   = 7'h20;
  localparam logic [6:0] subq_fn   = 7'h29;
  localparam logic [6:0] cmpeq_fn  = 7'h2d;
  localparam logic [6:0] cmplt_fn  = 7'h4d;
  localparam logic [6:0] cmple_fn  = 7'h6d;
  localparam logic [6:0] cmpult_fn = 7'h1d;
  localparam logic [6:0] cmpule_fn = 7'h3d;
  localparam logic [6:0] and_fn    = 7'h00;
  localparam logic [6:0] bic_fn    = 7'h08;
  localparam logic [6:0] bis_fn    = 7'h20;
  localparam logic [6:0] ornot_fn  = 7'h28;
  localparam logic [6:0] xor_fn    = 7'h40;
  localparam logic [6:0] eqv_fn    = 7'h48;
  localparam logic [6:0] srl_fn    = 7'h34;
  localparam logic [6:0] sll_fn    = 7'h39;
  localparam logic [6:0] sra_fn    = 7'h3c;
  localparam logic [6:0] mulq_fn   = 7'h20;

  typedef enum logic [4:0] {
    alu_addq, alu_subq, alu_cmpeq, alu_cmplt, alu_cmple, alu_cmpult, alu_cmpule,
    alu_and, alu_bic, alu_bis, alu_ornot, alu_xor, alu_eqv,
    alu_srl, alu_sll, alu_sra, alu_mulq
  } alu_func_e;

  typedef enum logic [1:0] {
    opa_is_rega     = 2'd0,
    opa_is_mem_disp = 2'd1,
    opa_is_npc      = 2'd2,
    opa_is_not3     = 2'd3 // ~3 mask, word-aligns jump target
  } opa_sel_e;

  typedef enum logic [1:0] {
    opb_is_regb    = 2'd0,
    opb_is_alu_imm = 2'd1,
    opb_is_br_disp = 2'd2
  } opb_sel_e;

  typedef struct packed {
    logic [5:0]           opcode;
    logic [reg_idx_w-1:0] ra;
    logic [reg_idx_w-1:0] rb;      // top of literal when lit set
    logic [2:0]           lit_or_zero;
    logic                 lit;     // bit 12
    logic [6:0]           func;
    logic [reg_idx_w-1:0] rc;
  } op_fmt_t;

  typedef struct packed {
    logic [5:0]           opcode;
    logic [reg_idx_w-1:0] ra;
    logic [reg_idx_w-1:0] rb;
    logic [15:0]          disp;
  } mem_fmt_t;

  typedef union packed {
    op_fmt_t  op;  // operate view
    mem_fmt_t mem; // memory / branch view
  } inst_word_u;

  typedef struct packed {
    logic        valid;
    logic [63:0] npc;
    inst_word_u  inst;
  } fetch_lane_t; // 97 bits

  typedef struct packed {
    logic [63:0]          npc;
    inst_word_u           inst;
    logic [reg_idx_w-1:0] ra_idx;
    logic [reg_idx_w-1:0] rb_idx;
    logic [reg_idx_w-1:0] rc_idx;
    logic [reg_idx_w-1:0] dest_idx;
    opa_sel_e             opa_sel;
    opb_sel_e             opb_sel;
    alu_func_e            alu_func;
    logic                 rd_mem;
    logic                 wr_mem;
    logic                 cond_branch;
    logic                 uncond_branch;
    logic                 halt;
    logic                 illegal;
    logic                 valid;
  } decoded_slot_t;

  // empty slot, also the reset contents of dispatch slots
  localparam decoded_slot_t noop_slot = '{
    npc: 64'd0, inst: noop_inst, ra_idx: zero_reg, rb_idx: zero_reg,
    rc_idx: zero_reg, dest_idx: zero_reg, opa_sel: opa_is_rega,
    opb_sel: opb_is_regb, alu_func: alu_addq, rd_mem: 1'b0, wr_mem: 1'b0,
    cond_branch: 1'b0, uncond_branch: 1'b0, halt: 1'b0, illegal: 1'b0,
    valid: 1'b0
  };

endpackage

`default_nettype wire
